/* Bender.yml */
package:
  name: scope_core

sources:
  - design/scope_pkg.sv
  - design/scope_if.sv
  - design/cmd_rx.sv
  - design/cmd_ctrl.sv
  - design/acq_ctrl.sv
  - design/sample_ram.sv
  - design/stream_tx.sv
  - design/scope_top.sv
  - target: test
    files:
      - verification/scope_chk.sv
      - verification/scope_tb.sv

/* design/acq_ctrl.sv */
/*
 * acquisition control
 * trigger FSM, buffer write address, post-trigger and event counters
 */
`timescale 1ns/1ps
`default_nettype none

module acq_ctrl #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rstn,
	input  scope_pkg::sample_t i_sample,
	input  logic              i_sample_valid,
	acq_if.acquisition        acq,
	output logic              o_wr_en,
	output logic [ADDR_W-1:0] o_wr_addr,
	output scope_pkg::sample_t o_wr_data
);
	import scope_pkg::*;

	acq_state_t        state;
	logic [ADDR_W-1:0] wr_addr;
	logic [7:0]        tot_cnt;           // samples seen beyond the second threshold
	logic [15:0]       post_cnt;
	logic [16:0]       post_next;         // post count including this cycle's sample
	logic [15:0]       event_count;
	logic [ADDR_W-1:0] trig_addr;
	logic              below;             // sample under lower threshold
	logic              above;             // sample over upper threshold

	assign below     = i_sample_valid && (i_sample < acq.cfg.lower_thr);
	assign above     = i_sample_valid && (i_sample > acq.cfg.upper_thr);
	assign post_next = 17'(post_cnt) + 17'(i_sample_valid);

	assign o_wr_en   = i_sample_valid && (state != ACQ_DONE);  // buffer frozen once done
	assign o_wr_addr = wr_addr;
	assign o_wr_data = i_sample;

	assign acq.state       = state;
	assign acq.event_count = event_count;
	assign acq.trig_addr   = trig_addr;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= ACQ_READY;
			wr_addr     <= '0;
			tot_cnt     <= 8'd0;
			post_cnt    <= 16'd0;
			event_count <= 16'd0;
			trig_addr   <= '0;
		end else begin
			if (o_wr_en)
				wr_addr <= wr_addr + 1'b1;       // circular, wraps at depth
			case (state)
				ACQ_READY: begin
					tot_cnt  <= 8'd0;
					post_cnt <= 16'd0;
					if (acq.arm) begin
						if (acq.cfg.trig_type == TRIG_RISE)
							state <= ACQ_RISE_LOW;
						else if (acq.cfg.trig_type == TRIG_FALL)
							state <= ACQ_FALL_HIGH;
						else begin
							trig_addr <= wr_addr;         // immediate trigger
							state     <= ACQ_POST;
						end
					end
				end
				ACQ_RISE_LOW:  if (below) state <= ACQ_RISE_HIGH;
				ACQ_FALL_HIGH: if (above) state <= ACQ_FALL_LOW;
				ACQ_RISE_HIGH, ACQ_FALL_LOW: begin
					// count is kept when the signal drops back
					if ((state == ACQ_RISE_HIGH) ? above : below) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= acq.cfg.tot) begin
							trig_addr <= wr_addr;         // address of this sample
							state     <= ACQ_POST;
						end
					end
				end
				ACQ_POST: begin
					post_cnt <= post_next[15:0];
					if (post_next >= 17'(acq.cfg.post_len)) begin
						event_count <= event_count + 16'd1;
						state       <= ACQ_DONE;
					end
				end
				ACQ_DONE: if (acq.readout_done) state <= ACQ_READY;
				default:  state <= ACQ_READY;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/cmd_ctrl.sv */
/*
 * command decoder
 * readout, arm/status, version and trigger settings
 * keeps the trigger settings and starts responses
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_ctrl (
	input  logic            clk,
	input  logic            rstn,
	input  logic            i_frame_valid,
	input  logic [7:0][7:0] i_frame,
	output logic            o_take,
	acq_if.controller       acq,
	resp_if.source          resp
);
	import scope_pkg::*;

	logic        act;                     // frame taken last cycle, decode now
	logic        ro_pending;              // readout in flight
	logic        busy_q;
	logic [11:0] lo_base;                 // b1 - b2 - 128
	logic [11:0] hi_base;                 // b1 + b2 - 128
	cmd_code_t   code;

	assign o_take  = i_frame_valid & ~resp.busy;
	assign code    = cmd_code_t'(i_frame[0]);
	assign lo_base = {4'd0, i_frame[1]} - {4'd0, i_frame[2]} - 12'd128;
	assign hi_base = {4'd0, i_frame[1]} + {4'd0, i_frame[2]} - 12'd128;

	// --------------------
	// control and settings
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			act               <= 1'b0;
			ro_pending        <= 1'b0;
			busy_q            <= 1'b0;
			resp.start        <= 1'b0;
			acq.arm           <= 1'b0;
			acq.readout_done  <= 1'b0;
			acq.cfg           <= '0;
		end else begin
			act              <= o_take;
			busy_q           <= resp.busy;
			resp.start       <= 1'b0;
			acq.arm          <= 1'b0;
			acq.readout_done <= 1'b0;
			if (ro_pending && busy_q && !resp.busy) begin
				acq.readout_done <= 1'b1;        // falling busy ends the readout
				ro_pending       <= 1'b0;
			end
			if (act) begin
				case (code)
					CMD_READOUT: begin
						resp.start <= 1'b1;
						ro_pending <= 1'b1;
					end
					CMD_ARM: begin
						acq.cfg.trig_type <= trig_type_t'(i_frame[1]);
						acq.cfg.post_len  <= {i_frame[5], i_frame[4]};
						acq.arm           <= 1'b1;
						resp.start        <= 1'b1;
					end
					CMD_VERSION: resp.start <= 1'b1;
					CMD_TRIG_SET: begin
						acq.cfg.lower_thr  <= sample_t'({lo_base[7:0], 4'd0} + 12'd8);
						acq.cfg.upper_thr  <= sample_t'({hi_base[7:0], 4'd0} + 12'd8);
						acq.cfg.pre_offset <= ADDR_W'({i_frame[3][1:0], i_frame[4]});
						acq.cfg.tot        <= i_frame[5];
						resp.start         <= 1'b1;
					end
					default: ;                     // unknown code, silently dropped
				endcase
			end
		end
	end

	// --------------------
	// response payload
	// --------------------
	always_ff @(posedge clk) begin
		if (act) begin
			resp.readout  <= (code == CMD_READOUT);
			resp.byte_len <= 32'd4;                        // one full beat
			resp.rd_base  <= acq.trig_addr - acq.cfg.pre_offset;
			case (code)
				CMD_READOUT:  resp.byte_len <= {i_frame[7], i_frame[6], i_frame[5], i_frame[4]};
				CMD_ARM:      resp.word <= {acq.event_count, 8'd0, acq.state};  // pre-arm status
				CMD_VERSION:  resp.word <= 32'(FW_VERSION);
				CMD_TRIG_SET: resp.word <= 32'(CMD_TRIG_SET);   // echo the code
				default:      resp.word <= 32'd0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/cmd_rx.sv */
/*
 * command receiver
 * packs 8 stream bytes into one frame, holds it until taken
 */
`timescale 1ns/1ps
`default_nettype none

module cmd_rx (
	input  logic            clk,
	input  logic            rstn,
	input  logic            i_valid,
	input  logic [7:0]      i_data,
	output logic            o_ready,
	output logic            o_frame_valid,
	output logic [7:0][7:0] o_frame,
	input  logic            i_take
);

	logic [2:0]      byte_cnt;            // next byte slot
	logic            full;                // complete frame held
	logic [7:0][7:0] frame;
	logic            accept;

	assign accept        = i_valid & ~full;  // byte transfer this cycle
	assign o_ready       = ~full;            // stall host while a frame waits
	assign o_frame_valid = full;
	assign o_frame       = frame;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt <= 3'd0;
			full     <= 1'b0;
		end else begin
			if (accept) begin
				byte_cnt <= byte_cnt + 3'd1;     // wraps to 0 after byte 7
				if (byte_cnt == 3'd7)
					full <= 1'b1;
			end
			if (i_take)
				full <= 1'b0;                    // frees the receiver for the next command
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			frame[byte_cnt] <= i_data;          // byte 0 is the command code
	end

endmodule

`default_nettype wire

/* design/sample_ram.sv */
/*
 * circular sample buffer, one write port, registered read
 */
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) (
	input  logic               clk,
	input  logic               i_wr_en,
	input  logic [ADDR_W-1:0]  i_wr_addr,
	input  scope_pkg::sample_t i_wr_data,
	input  logic [ADDR_W-1:0]  i_rd_addr,
	output scope_pkg::sample_t o_rd_data
);

	scope_pkg::sample_t mem [2**ADDR_W];  // inferred block ram

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];       // data valid one cycle after address
	end

endmodule

`default_nettype wire

/* design/scope_if.sv */
/*
 * acq_if: settings and status between command decoder and acquisition
 * resp_if: response requests from command decoder to stream sender
 */
`timescale 1ns/1ps
`default_nettype none

interface acq_if #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) ();
	import scope_pkg::*;

	trig_cfg_t         cfg;               // current trigger settings
	logic              arm;               // one-cycle pulse, only acts in ACQ_READY
	logic              readout_done;      // one-cycle pulse after a buffer readout
	acq_state_t        state;
	logic [15:0]       event_count;
	logic [ADDR_W-1:0] trig_addr;         // write address of the triggering sample

	modport controller  (output cfg, arm, readout_done, input state, event_count, trig_addr);
	modport acquisition (input cfg, arm, readout_done, output state, event_count, trig_addr);
endinterface

interface resp_if #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) ();
	logic              start;             // one-cycle pulse, never while busy
	logic              readout;           // 1 = stream buffer contents, 0 = send word
	logic [31:0]       word;
	logic [31:0]       byte_len;
	logic [ADDR_W-1:0] rd_base;           // first buffer address of a readout
	logic              busy;

	modport source (output start, readout, word, byte_len, rd_base, input busy);
	modport sink   (input start, readout, word, byte_len, rd_base, output busy);
endinterface

`default_nettype wire

/* design/scope_pkg.sv */
/*
 * shared widths, command codes, acquisition state codes,
 * trigger types and the trigger settings struct
 */
`default_nettype none

package scope_pkg;

	// --------------------
	// widths and constants
	// --------------------
	localparam int SAMPLE_W   = 12;       // adc sample width
	localparam int ADDR_W     = 10;       // sample buffer address width
	localparam int FW_VERSION = 18;       // returned by the version command

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// --------------------
	// encodings
	// --------------------
	typedef enum logic [7:0] {
		CMD_READOUT  = 8'd0,              // read the sample buffer
		CMD_ARM      = 8'd1,              // arm trigger and return status
		CMD_VERSION  = 8'd2,
		CMD_TRIG_SET = 8'd8               // thresholds, pre-offset, tot
	} cmd_code_t;

	typedef enum logic [7:0] {
		ACQ_READY     = 8'd0,
		ACQ_RISE_LOW  = 8'd1,             // waiting to go below lower threshold
		ACQ_RISE_HIGH = 8'd2,             // counting samples above upper threshold
		ACQ_FALL_HIGH = 8'd3,
		ACQ_FALL_LOW  = 8'd4,
		ACQ_POST      = 8'd250,           // taking post-trigger samples
		ACQ_DONE      = 8'd251            // event held until read out
	} acq_state_t;

	typedef enum logic [7:0] {
		TRIG_NOW  = 8'd0,
		TRIG_RISE = 8'd1,
		TRIG_FALL = 8'd2
	} trig_type_t;

	typedef struct packed {
		sample_t           lower_thr;     // signed, compared against samples
		sample_t           upper_thr;
		logic [ADDR_W-1:0] pre_offset;    // readout starts this far before trigger
		logic [7:0]        tot;           // time over threshold, in samples
		trig_type_t        trig_type;
		logic [15:0]       post_len;      // samples taken after the trigger
	} trig_cfg_t;

endpackage

`default_nettype wire

/* design/scope_top.sv */
/*
 * scope core top level
 * command receiver, decoder, acquisition, sample buffer, response sender
 */
`timescale 1ns/1ps
`default_nettype none

module scope_top #(
	parameter int ADDR_W = 10
) (
	input  logic               clk,
	input  logic               rstn,
	input  logic               i_rx_valid,
	input  logic [7:0]         i_rx_data,
	output logic               o_rx_ready,
	input  logic               i_tx_ready,
	output logic               o_tx_valid,
	output logic [31:0]        o_tx_data,
	output logic [3:0]         o_tx_keep,
	output logic               o_tx_last,
	input  scope_pkg::sample_t i_sample,
	input  logic               i_sample_valid
);

	logic               frame_valid;
	logic [7:0][7:0]    frame;
	logic               frame_take;
	logic               wr_en;
	logic [ADDR_W-1:0]  wr_addr;
	scope_pkg::sample_t wr_data;
	logic [ADDR_W-1:0]  rd_addr;
	scope_pkg::sample_t rd_data;

	acq_if  #(.ADDR_W(ADDR_W)) acq_bus  ();  // decoder <-> acquisition
	resp_if #(.ADDR_W(ADDR_W)) resp_bus ();  // decoder -> sender

	cmd_rx u_cmd_rx (
		.clk(clk), .rstn(rstn),
		.i_valid(i_rx_valid), .i_data(i_rx_data), .o_ready(o_rx_ready),
		.o_frame_valid(frame_valid), .o_frame(frame), .i_take(frame_take)
	);

	cmd_ctrl u_cmd_ctrl (
		.clk(clk), .rstn(rstn),
		.i_frame_valid(frame_valid), .i_frame(frame), .o_take(frame_take),
		.acq(acq_bus.controller), .resp(resp_bus.source)
	);

	acq_ctrl #(.ADDR_W(ADDR_W)) u_acq_ctrl (
		.clk(clk), .rstn(rstn),
		.i_sample(i_sample), .i_sample_valid(i_sample_valid), .acq(acq_bus.acquisition),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
	);

	sample_ram #(.ADDR_W(ADDR_W)) u_sample_ram (
		.clk(clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	stream_tx #(.ADDR_W(ADDR_W)) u_stream_tx (
		.clk(clk), .rstn(rstn), .resp(resp_bus.sink),
		.o_rd_addr(rd_addr), .i_rd_data(rd_data),
		.i_tx_ready(i_tx_ready), .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data),
		.o_tx_keep(o_tx_keep), .o_tx_last(o_tx_last)
	);

endmodule

`default_nettype wire

/* design/stream_tx.sv */
/*
 * response sender, 32-bit stream with keep and last
 * single word replies and buffer readout, two samples per beat
 */
`timescale 1ns/1ps
`default_nettype none

module stream_tx #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) (
	input  logic               clk,
	input  logic               rstn,
	resp_if.sink               resp,
	output logic [ADDR_W-1:0]  o_rd_addr,
	input  scope_pkg::sample_t i_rd_data,
	input  logic               i_tx_ready,
	output logic               o_tx_valid,
	output logic [31:0]        o_tx_data,
	output logic [3:0]         o_tx_keep,
	output logic               o_tx_last
);
	import scope_pkg::*;

	typedef enum logic [2:0] {TX_IDLE, TX_ADDR_LO, TX_ADDR_HI, TX_LOAD, TX_SEND} tx_state_t;

	localparam int PAD_W = 16 - SAMPLE_W;  // zero fill to 16-bit halves

	tx_state_t         state;
	logic [31:0]       rem;               // bytes left, current beat included
	logic [ADDR_W-1:0] ptr;               // next buffer address
	sample_t           lo_half;
	logic              tx_last;

	assign tx_last    = (rem <= 32'd4);
	assign o_tx_last  = tx_last;
	assign o_rd_addr  = ptr;
	assign resp.busy  = (state != TX_IDLE);

	always_comb begin
		case (rem[1:0])
			2'd3:    o_tx_keep = 4'b0111;
			2'd2:    o_tx_keep = 4'b0011;
			2'd1:    o_tx_keep = 4'b0001;
			default: o_tx_keep = 4'b0000;   // byte_len of 0
		endcase
		if (rem >= 32'd4)
			o_tx_keep = 4'b1111;
	end

	// --------------------
	// beat sequencing
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= TX_IDLE;
			o_tx_valid <= 1'b0;
			rem        <= 32'd0;
		end else begin
			case (state)
				TX_IDLE: if (resp.start) begin
					rem <= resp.byte_len;
					if (resp.readout)
						state <= TX_ADDR_LO;
					else begin
						o_tx_valid <= 1'b1;           // word is ready right away
						state      <= TX_SEND;
					end
				end
				TX_ADDR_LO: state <= TX_ADDR_HI;
				TX_ADDR_HI: state <= TX_LOAD;
				TX_LOAD: begin
					o_tx_valid <= 1'b1;
					state      <= TX_SEND;
				end
				TX_SEND: if (i_tx_ready) begin
					o_tx_valid <= 1'b0;
					if (tx_last)
						state <= TX_IDLE;
					else begin
						rem   <= rem - 32'd4;
						state <= TX_ADDR_LO;          // fetch the next pair
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// --------------------
	// data path
	// --------------------
	always_ff @(posedge clk) begin
		case (state)
			TX_IDLE: if (resp.start) begin
				ptr       <= resp.rd_base;
				o_tx_data <= resp.word;
			end
			TX_ADDR_LO: ptr <= ptr + 1'b1;   // low sample address is on the ram
			TX_ADDR_HI: begin
				lo_half <= i_rd_data;
				ptr     <= ptr + 1'b1;
			end
			TX_LOAD: o_tx_data <= {{PAD_W{1'b0}}, i_rd_data, {PAD_W{1'b0}}, lo_half};
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* scope_top.f */
design/scope_pkg.sv
design/scope_if.sv
design/cmd_rx.sv
design/cmd_ctrl.sv
design/acq_ctrl.sv
design/sample_ram.sv
design/stream_tx.sv
design/scope_top.sv
verification/scope_chk.sv
verification/scope_tb.sv

/* verification/scope_chk.sv */
/*
 * response stream protocol assertions
 * bound to the scope core top level
 */
`timescale 1ns/1ps
`default_nettype none

module scope_chk (
	input logic        clk,
	input logic        rstn,
	input logic        i_tx_ready,
	input logic        i_tx_valid,
	input logic [31:0] i_tx_data,
	input logic [3:0]  i_tx_keep,
	input logic        i_tx_last
);

	int fail_cnt = 0;                     // failed assertion count

	// a stalled beat stays put until the host takes it
	hold_beat: assert property (@(posedge clk) disable iff (!rstn)
		i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx_data)
			&& $stable(i_tx_keep) && $stable(i_tx_last))
	else begin
		$error("stream beat changed while stalled");
		fail_cnt++;
	end

	idle_in_reset: assert property (@(posedge clk) !rstn |-> !i_tx_valid)
	else begin
		$error("stream valid high during reset");
		fail_cnt++;
	end

	full_keep: assert property (@(posedge clk) disable iff (!rstn)
		!i_tx_last |-> i_tx_keep == 4'b1111)  // only the last beat may be partial
	else begin
		$error("partial keep on a beat that is not the last");
		fail_cnt++;
	end

endmodule

bind scope_top scope_chk u_chk (
	.clk(clk), .rstn(rstn), .i_tx_ready(i_tx_ready), .i_tx_valid(o_tx_valid),
	.i_tx_data(o_tx_data), .i_tx_keep(o_tx_keep), .i_tx_last(o_tx_last)
);

`default_nettype wire

/* verification/scope_tb.sv */
/*
 * scope core testbench
 * directed command, trigger and readout tests
 * sample buffer model, random back-pressure, cycle limit
 */
`timescale 1ns/1ps
`default_nettype none

module scope_tb;
	import scope_pkg::*;

	localparam int DEPTH     = 2**ADDR_W;
	localparam int SAMPLES   = 180;       // samples fed over all tests
	localparam int BEATS     = 45;        // response beats over all tests
	localparam int CMD_BYTES = 16 * 8;
	localparam int LIMIT_CYC = 4 * (2 * SAMPLES + 8 * BEATS + 2 * CMD_BYTES);
	localparam logic signed [11:0] LOW_V  = -12'sd500;
	localparam logic signed [11:0] HIGH_V = 12'sd700;

	logic               clk = 1'b0;
	logic               rstn;
	logic               i_rx_valid;
	logic [7:0]         i_rx_data;
	logic               o_rx_ready;
	logic               i_tx_ready;
	logic               o_tx_valid;
	logic [31:0]        o_tx_data;
	logic [3:0]         o_tx_keep;
	logic               o_tx_last;
	logic signed [11:0] i_sample;
	logic               i_sample_valid;

	logic [11:0]        model_mem [DEPTH];  // expected buffer contents
	int                 wp;                 // model write address
	int                 m_ev;               // model event count
	logic signed [11:0] m_lo;
	logic signed [11:0] m_hi;
	int                 m_pre;
	int                 m_tot;
	logic [31:0]        rng = 32'h6363;
	int                 cyc;

	scope_top #(.ADDR_W(ADDR_W)) uut (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .o_rx_ready(o_rx_ready),
		.i_tx_ready(i_tx_ready), .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data),
		.o_tx_keep(o_tx_keep), .o_tx_last(o_tx_last),
		.i_sample(i_sample), .i_sample_valid(i_sample_valid)
	);

	always #20 clk = ~clk;                  // 40 ns period

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Something failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// --------------------
	// bus level tasks
	// --------------------
	task automatic step();                  // next edge plus drive delay
		@(posedge clk);
		#2;
		cyc++;
		if (cyc > LIMIT_CYC)
			report_error("timeout, the DUT did not finish within the cycle limit");
	endtask

	task automatic apply_reset();
		rstn = 1'b0;
		wp   = 0;
		m_ev = 0;
		repeat (3) step();
		rstn = 1'b1;
		@(negedge clk);
		assert (o_rx_ready)
			else report_error($sformatf("Mismatch o_rx_ready: got %h, expected 1", o_rx_ready));
	endtask

	task automatic send_cmd(input logic [63:0] cmd);  // byte 0 goes first
		int i;
		for (i = 0; i < 8; i++) begin
			step();
			i_rx_valid = 1'b1;
			i_rx_data  = cmd[8*i +: 8];
			@(negedge clk);
			while (!o_rx_ready) begin
				step();
				@(negedge clk);
			end
		end
		step();
		i_rx_valid = 1'b0;
	endtask

	task automatic feed_sample(input logic signed [11:0] v);
		step();
		i_sample       = v;
		i_sample_valid = 1'b1;
		model_mem[wp]  = v;
		wp             = (wp + 1) % DEPTH;
		step();
		i_sample_valid = 1'b0;
	endtask

	task automatic recv_beat(input logic bp, output logic [31:0] d, output logic [3:0] k,
			output logic l);
		logic got;
		got = 1'b0;
		while (!got) begin
			step();
			rng        = xorshift32(rng);
			i_tx_ready = bp ? rng[7] : 1'b1;  // random stall
			@(negedge clk);
			if (o_tx_valid && i_tx_ready) begin
				d   = o_tx_data;
				k   = o_tx_keep;
				l   = o_tx_last;
				got = 1'b1;
			end
		end
	endtask

	task automatic expect_word(input logic [31:0] exp);
		logic [31:0] d;
		logic [3:0]  k;
		logic        l;
		recv_beat(1'b0, d, k, l);
		assert (d == exp)
			else report_error($sformatf("Mismatch o_tx_data: got %h, expected %h", d, exp));
		assert (k == 4'hf)
			else report_error($sformatf("Mismatch o_tx_keep: got %h, expected f", k));
		assert (l)
			else report_error("single word response came without o_tx_last");
	endtask

	// --------------------
	// command tasks
	// --------------------
	task automatic set_trigger(input int b1, b2, b3, b4, b5);
		int lo;
		int hi;
		lo    = 16 * (b1 - b2 - 128) + 8;
		hi    = 16 * (b1 + b2 - 128) + 8;
		m_lo  = lo[11:0];
		m_hi  = hi[11:0];
		m_pre = 256 * (b3 % 4) + b4;
		m_tot = b5;
		send_cmd({16'h0, 8'(b5), 8'(b4), 8'(b3), 8'(b2), 8'(b1), CMD_TRIG_SET});
		expect_word(32'd8);
	endtask

	// arm command, reply is the status from before the arm
	task automatic check_status(input logic [7:0] ttype, input logic [15:0] post,
			input logic [7:0] exp_state);
		send_cmd({16'h0, post, 16'h0, ttype, CMD_ARM});
		expect_word({m_ev[15:0], 8'h00, exp_state});
	endtask

	task automatic run_readout(input int len, input int base);
		int          beats;
		int          beat;
		int          rem;
		int          a;
		logic [31:0] d;
		logic [31:0] exp;
		logic [31:0] mask;
		logic [3:0]  kg;
		logic [3:0]  ke;
		logic        l;
		send_cmd({len[31:0], 24'h0, CMD_READOUT});
		beats = (len == 0) ? 1 : (len + 3) / 4;
		for (beat = 0; beat < beats; beat++) begin
			recv_beat(1'b1, d, kg, l);
			a    = base + 2 * beat;
			exp  = {4'h0, model_mem[(a + 1) % DEPTH], 4'h0, model_mem[a % DEPTH]};
			rem  = len - 4 * beat;
			ke   = (rem >= 4) ? 4'hf : 4'((1 << rem) - 1);
			mask = {{8{ke[3]}}, {8{ke[2]}}, {8{ke[1]}}, {8{ke[0]}}};  // valid bytes only
			assert ((d & mask) == (exp & mask))
				else report_error($sformatf("Mismatch o_tx_data: got %h, expected %h", d, exp));
			assert (kg == ke)
				else report_error($sformatf("Mismatch o_tx_keep: got %h, expected %h", kg, ke));
			assert (l == (beat == beats - 1))
				else report_error($sformatf("Mismatch o_tx_last: got %h, expected %h", l,
					beat == beats - 1));
		end
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic test_version();
		send_cmd({56'h0, CMD_VERSION});
		expect_word(32'(FW_VERSION));
	endtask

	task automatic test_settings_idle();
		set_trigger(128, 8, 0, 32, 3);
		check_status(8'd5, 16'd0, ACQ_READY);
		apply_reset();                      // odd type armed an acquisition
	endtask

	task automatic test_immediate();
		int i;
		int trig;
		set_trigger(100, 20, 0, 32, 0);     // pre-offset 32
		for (i = 0; i < 100; i++) begin
			rng = xorshift32(rng);
			feed_sample(rng[11:0]);
		end
		trig = wp;                          // next write address becomes the trigger
		check_status(TRIG_NOW, 16'd40, ACQ_READY);
		for (i = 0; i < 40; i++) begin
			rng = xorshift32(rng);
			feed_sample(rng[11:0]);
		end
		m_ev++;
		check_status(TRIG_NOW, 16'd40, ACQ_DONE);
		run_readout(80, (trig - m_pre + DEPTH) % DEPTH);
	endtask

	task automatic test_rising();
		int                 i;
		int                 trig;
		int                 n_above;
		logic               low_seen;
		logic signed [11:0] v;
		trig     = -1;
		n_above  = 0;
		low_seen = 1'b0;
		set_trigger(128, 8, 0, 4, 3);       // lower -120, upper 136, tot 3
		check_status(TRIG_RISE, 16'd16, ACQ_READY);
		for (i = 0; i < 20 && trig < 0; i++) begin
			if (i < 4)
				v = 12'sd0;
			else if (i < 7)
				v = LOW_V;
			else
				v = (i % 3 == 0) ? 12'sd0 : HIGH_V;  // dips keep the count
			if (!low_seen)
				low_seen = (v < m_lo);
			else if (v > m_hi) begin
				if (n_above >= m_tot)
					trig = wp;
				n_above++;
			end
			feed_sample(v);
		end
		assert (trig >= 0) else report_error("rising trigger condition was never reached");
		for (i = 0; i < 16; i++) begin
			rng = xorshift32(rng);
			feed_sample(rng[11:0]);
		end
		m_ev++;
		check_status(TRIG_NOW, 16'd16, ACQ_DONE);
		run_readout(32, (trig - m_pre + DEPTH) % DEPTH);
	endtask

	task automatic test_partial();
		int i;
		int trig;
		trig = wp;
		check_status(TRIG_NOW, 16'd6, ACQ_READY);
		for (i = 0; i < 6; i++) begin
			rng = xorshift32(rng);
			feed_sample(rng[11:0]);
		end
		m_ev++;
		run_readout(14, (trig - m_pre + DEPTH) % DEPTH);  // 3 full beats, 2 bytes
		check_status(TRIG_RISE, 16'd0, ACQ_READY);
	endtask

	task automatic test_unknown();
		int i;
		send_cmd({56'h0, 8'h05});
		i_tx_ready = 1'b1;
		for (i = 0; i < 24; i++) begin
			step();
			@(negedge clk);
			assert (!o_tx_valid) else report_error("response beat sent for an unknown command");
		end
		test_version();
	endtask

	initial begin
		rstn           = 1'b0;
		i_rx_valid     = 1'b0;
		i_rx_data      = 8'h00;
		i_tx_ready     = 1'b0;
		i_sample       = '0;
		i_sample_valid = 1'b0;
		cyc            = 0;
		apply_reset();
		test_version();
		test_settings_idle();
		test_immediate();
		test_rising();
		test_partial();
		test_unknown();
		if (uut.u_chk.fail_cnt == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "stream protocol assertions failed");
		end
	end

endmodule

`default_nettype wire
